// File: source/bellmanFordConsts.svh
`ifndef BELLMAN_FORD_CONSTS_SVH
`define BELLMAN_FORD_CONSTS_SVH

`define BF_NODE_WIDTH 8
`define BF_WEIGHT_WIDTH 8
`define BF_DIST_WIDTH 16
`define BF_ADDR_WIDTH 13
`define BF_LINE_WIDTH 128

`define BF_MAX_NODES 32

// Pairs per graph line
`define BF_FIRST_PAIRS 7
`define BF_NEXT_PAIRS 8

// Link count field of a first line
`define BF_COUNT_MSB 119
`define BF_COUNT_LSB 112

`define BF_PATH_END 16'hFFFF

`endif

// File: source/bellmanFordPkg.sv
`include "bellmanFordConsts.svh"

package bellmanFordPkg;

    // Node 0 is never a valid node
    typedef logic [`BF_NODE_WIDTH-1:0] nodeId_t;

    typedef logic signed [`BF_WEIGHT_WIDTH-1:0] weight_t;

    typedef logic signed [`BF_DIST_WIDTH-1:0] distance_t;

    typedef logic [`BF_ADDR_WIDTH-1:0] graphAddress_t;

    typedef logic [`BF_LINE_WIDTH-1:0] graphLine_t;

endpackage

// File: source/distanceTable.sv
`include "bellmanFordConsts.svh"

module distanceTable (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      initialize,
    input  bellmanFordPkg::nodeId_t   initNode,
    input  logic                      writeEnable,
    input  bellmanFordPkg::nodeId_t   writeNode,
    input  bellmanFordPkg::nodeId_t   writePredecessor,
    input  bellmanFordPkg::distance_t writeDistance,
    input  bellmanFordPkg::nodeId_t   scanNode,
    output logic                      scanReached,
    output bellmanFordPkg::distance_t scanDistance,
    input  bellmanFordPkg::nodeId_t   relaxNode,
    output logic                      relaxReached,
    output bellmanFordPkg::distance_t relaxDistance,
    input  bellmanFordPkg::nodeId_t   pathNode,
    output logic                      pathReached,
    output bellmanFordPkg::distance_t pathDistance,
    output bellmanFordPkg::nodeId_t   pathPredecessor
);
    localparam int indexWidth = $clog2(`BF_MAX_NODES);

    logic                      reached [`BF_MAX_NODES];
    bellmanFordPkg::distance_t distance [`BF_MAX_NODES];
    bellmanFordPkg::nodeId_t   predecessor [`BF_MAX_NODES];

    always_ff @(posedge clock)
    begin
        if (reset || initialize)
        begin
            for (int i = 0; i < `BF_MAX_NODES; i++)
                reached[i] <= 1'b0;
        end
        // Source starts at distance 0 and points to itself
        if (!reset && initialize)
        begin
            reached[initNode[indexWidth-1:0]] <= 1'b1;
            distance[initNode[indexWidth-1:0]] <= '0;
            predecessor[initNode[indexWidth-1:0]] <= initNode;
        end
        else if (!reset && writeEnable)
        begin
            reached[writeNode[indexWidth-1:0]] <= 1'b1;
            distance[writeNode[indexWidth-1:0]] <= writeDistance;
            predecessor[writeNode[indexWidth-1:0]] <= writePredecessor;
        end
    end

    assign scanReached = reached[scanNode[indexWidth-1:0]];
    assign scanDistance = distance[scanNode[indexWidth-1:0]];
    assign relaxReached = reached[relaxNode[indexWidth-1:0]];
    assign relaxDistance = distance[relaxNode[indexWidth-1:0]];
    assign pathReached = reached[pathNode[indexWidth-1:0]];
    assign pathDistance = distance[pathNode[indexWidth-1:0]];
    assign pathPredecessor = predecessor[pathNode[indexWidth-1:0]];

    writeInTable: assert property (@(posedge clock) disable iff (reset)
        writeEnable |-> writeNode != '0 && writeNode < `BF_MAX_NODES);

endmodule

// File: source/adjacencyFetch.sv
`include "bellmanFordConsts.svh"

module adjacencyFetch (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          fetchStart,
    input  bellmanFordPkg::nodeId_t       fetchNode,
    input  bellmanFordPkg::nodeId_t       nodeCount,
    output logic                          graphReadEnable,
    output bellmanFordPkg::graphAddress_t graphAddress,
    input  bellmanFordPkg::graphLine_t    graphData,
    output logic                          edgeValid,
    output bellmanFordPkg::nodeId_t       edgeNode,
    output bellmanFordPkg::weight_t       edgeWeight,
    output logic                          fetchDone
);
    localparam int pairWidth = `BF_NODE_WIDTH + `BF_WEIGHT_WIDTH;

    typedef enum logic [2:0] {
        stateIdle,
        stateIndexWait,
        stateIndex,
        stateLineWait,
        stateLine,
        stateEmit,
        stateDone
    } fetchState_t;

    fetchState_t                state;
    bellmanFordPkg::graphLine_t pairBuffer;
    bellmanFordPkg::nodeId_t    linksLeft;
    bellmanFordPkg::nodeId_t    pairsLeft;
    bellmanFordPkg::nodeId_t    linkTotal;
    bellmanFordPkg::nodeId_t    linePairs;
    bellmanFordPkg::nodeId_t    lineCapacity;
    logic                       firstLine;

    // Pairs to use from the line on graphData
    always_comb
    begin
        lineCapacity = firstLine ? bellmanFordPkg::nodeId_t'(`BF_FIRST_PAIRS)
                                 : bellmanFordPkg::nodeId_t'(`BF_NEXT_PAIRS);
        linkTotal = firstLine ? graphData[`BF_COUNT_MSB:`BF_COUNT_LSB] : linksLeft;
        linePairs = (linkTotal < lineCapacity) ? linkTotal : lineCapacity;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= stateIdle;
            graphReadEnable <= 1'b0;
            edgeValid <= 1'b0;
            fetchDone <= 1'b0;
        end
        else
        begin
            graphReadEnable <= 1'b0;
            edgeValid <= 1'b0;
            fetchDone <= 1'b0;
            case (state)
                stateIdle:
                begin
                    if (fetchStart)
                    begin
                        graphReadEnable <= 1'b1;
                        graphAddress <= bellmanFordPkg::graphAddress_t'(fetchNode);
                        state <= stateIndexWait;
                    end
                end
                stateIndexWait:
                    state <= stateIndex;
                stateIndex:
                begin
                    graphReadEnable <= 1'b1;
                    graphAddress <= graphData[`BF_ADDR_WIDTH-1:0];
                    firstLine <= 1'b1;
                    state <= stateLineWait;
                end
                stateLineWait:
                    state <= stateLine;
                stateLine:
                begin
                    linksLeft <= linkTotal;
                    pairsLeft <= linePairs;
                    // Align the first pair to the top of the buffer
                    pairBuffer <= firstLine ? graphData << pairWidth : graphData;
                    firstLine <= 1'b0;
                    if (linkTotal == '0)
                    begin
                        fetchDone <= 1'b1;
                        state <= stateIdle;
                    end
                    else
                        state <= stateEmit;
                end
                stateEmit:
                begin
                    edgeValid <= 1'b1;
                    edgeNode <= pairBuffer[`BF_LINE_WIDTH-1 -: `BF_NODE_WIDTH];
                    edgeWeight <= pairBuffer[`BF_LINE_WIDTH-`BF_NODE_WIDTH-1 -: `BF_WEIGHT_WIDTH];
                    pairBuffer <= pairBuffer << pairWidth;
                    pairsLeft <= pairsLeft - 1'b1;
                    linksLeft <= linksLeft - 1'b1;
                    if (linksLeft == 8'd1)
                        state <= stateDone;
                    else if (pairsLeft == 8'd1)
                    begin
                        // Continuation line sits at the next address
                        graphReadEnable <= 1'b1;
                        graphAddress <= graphAddress + 1'b1;
                        state <= stateLineWait;
                    end
                end
                stateDone:
                begin
                    fetchDone <= 1'b1;
                    state <= stateIdle;
                end
                default:
                    state <= stateIdle;
            endcase
        end
    end

    neighborInRange: assert property (@(posedge clock) disable iff (reset)
        edgeValid |-> edgeNode != '0 && edgeNode <= nodeCount);

endmodule

// File: source/edgeRelaxer.sv
`include "bellmanFordConsts.svh"

module edgeRelaxer (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      edgeValid,
    input  bellmanFordPkg::nodeId_t   edgeNode,
    input  bellmanFordPkg::weight_t   edgeWeight,
    input  bellmanFordPkg::nodeId_t   sourceNode,
    input  bellmanFordPkg::distance_t sourceDistance,
    output bellmanFordPkg::nodeId_t   relaxNode,
    input  logic                      relaxReached,
    input  bellmanFordPkg::distance_t relaxDistance,
    output logic                      writeEnable,
    output bellmanFordPkg::nodeId_t   writeNode,
    output bellmanFordPkg::nodeId_t   writePredecessor,
    output bellmanFordPkg::distance_t writeDistance,
    output logic                      relaxerIdle
);
    logic                      stageValid;
    bellmanFordPkg::nodeId_t   stageNode;
    bellmanFordPkg::distance_t stageCandidate;
    logic                      targetReached;
    bellmanFordPkg::distance_t targetDistance;
    logic                      improves;

    assign relaxNode = stageNode;
    assign relaxerIdle = !stageValid && !writeEnable;

    always_comb
    begin
        // Write in stage two has not reached the table yet
        if (writeEnable && writeNode == stageNode)
        begin
            targetReached = 1'b1;
            targetDistance = writeDistance;
        end
        else
        begin
            targetReached = relaxReached;
            targetDistance = relaxDistance;
        end
        improves = stageValid && (!targetReached || stageCandidate < targetDistance);
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            stageValid <= 1'b0;
            writeEnable <= 1'b0;
        end
        else
        begin
            stageValid <= edgeValid;
            writeEnable <= improves;
        end
    end

    always_ff @(posedge clock)
    begin
        if (edgeValid)
        begin
            stageNode <= edgeNode;
            stageCandidate <= sourceDistance + bellmanFordPkg::distance_t'(edgeWeight);
        end
        if (improves)
        begin
            writeNode <= stageNode;
            writeDistance <= stageCandidate;
            writePredecessor <= sourceNode;
        end
    end

endmodule

// File: source/passController.sv
`include "bellmanFordConsts.svh"

module passController (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start,
    input  bellmanFordPkg::nodeId_t   source,
    input  bellmanFordPkg::nodeId_t   destination,
    input  bellmanFordPkg::nodeId_t   nodeCount,
    output logic                      busy,
    output logic                      finish,
    output logic                      negCycle,
    output logic                      initialize,
    output bellmanFordPkg::nodeId_t   initNode,
    output bellmanFordPkg::nodeId_t   scanNode,
    input  logic                      scanReached,
    input  bellmanFordPkg::distance_t scanDistance,
    output logic                      fetchStart,
    output bellmanFordPkg::nodeId_t   fetchNode,
    output bellmanFordPkg::nodeId_t   sourceNode,
    output bellmanFordPkg::distance_t sourceDistance,
    input  logic                      fetchDone,
    input  logic                      relaxerIdle,
    input  logic                      updated,
    output logic                      walkStart,
    output bellmanFordPkg::nodeId_t   walkSource,
    output bellmanFordPkg::nodeId_t   walkDestination,
    input  logic                      pathDone
);
    typedef enum logic [2:0] {
        stateIdle,
        stateInit,
        stateScan,
        stateWaitFetch,
        stateWaitRelax,
        stateEndPass,
        stateWalk,
        stateFinish
    } passState_t;

    passState_t              state;
    bellmanFordPkg::nodeId_t sourceReg;
    bellmanFordPkg::nodeId_t destinationReg;
    bellmanFordPkg::nodeId_t nodeCountReg;
    bellmanFordPkg::nodeId_t currentNode;
    bellmanFordPkg::nodeId_t passCount;
    logic                    passUpdated;
    logic                    advance;

    assign busy = state != stateIdle;
    assign finish = state == stateFinish;
    assign initialize = state == stateInit;
    assign initNode = sourceReg;
    assign scanNode = currentNode;
    assign fetchStart = state == stateScan && scanReached;
    assign fetchNode = currentNode;
    assign sourceNode = currentNode;
    assign walkStart = state == stateEndPass && !passUpdated;
    assign walkSource = sourceReg;
    assign walkDestination = destinationReg;

    // Unreached nodes are skipped within the pass
    assign advance = (state == stateScan && !scanReached)
                  || (state == stateWaitRelax && relaxerIdle);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= stateIdle;
            negCycle <= 1'b0;
            passUpdated <= 1'b0;
        end
        else
        begin
            if (updated)
                passUpdated <= 1'b1;
            case (state)
                stateIdle:
                begin
                    if (start)
                    begin
                        sourceReg <= source;
                        destinationReg <= destination;
                        nodeCountReg <= nodeCount;
                        negCycle <= 1'b0;
                        state <= stateInit;
                    end
                end
                stateInit:
                begin
                    currentNode <= 8'd1;
                    passCount <= 8'd1;
                    passUpdated <= 1'b0;
                    state <= stateScan;
                end
                stateScan:
                begin
                    sourceDistance <= scanDistance;
                    if (scanReached)
                        state <= stateWaitFetch;
                end
                stateWaitFetch:
                begin
                    if (fetchDone)
                        state <= stateWaitRelax;
                end
                stateEndPass:
                begin
                    if (!passUpdated)
                        state <= stateWalk;
                    else if (passCount == nodeCountReg)
                    begin
                        // Still relaxing after nodeCount passes
                        negCycle <= 1'b1;
                        state <= stateFinish;
                    end
                    else
                    begin
                        passCount <= passCount + 1'b1;
                        currentNode <= 8'd1;
                        passUpdated <= 1'b0;
                        state <= stateScan;
                    end
                end
                stateWalk:
                begin
                    if (pathDone)
                        state <= stateFinish;
                end
                stateFinish:
                    state <= stateIdle;
                default:
                    ;
            endcase
            if (advance)
            begin
                if (currentNode == nodeCountReg)
                    state <= stateEndPass;
                else
                begin
                    currentNode <= currentNode + 1'b1;
                    state <= stateScan;
                end
            end
        end
    end

endmodule

// File: source/pathWriter.sv
`include "bellmanFordConsts.svh"

module pathWriter (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          walkStart,
    input  bellmanFordPkg::nodeId_t       walkSource,
    input  bellmanFordPkg::nodeId_t       walkDestination,
    output bellmanFordPkg::nodeId_t       pathNode,
    input  logic                          pathReached,
    input  bellmanFordPkg::distance_t     pathDistance,
    input  bellmanFordPkg::nodeId_t       pathPredecessor,
    output logic                          outWriteEnable,
    output bellmanFordPkg::graphAddress_t outAddress,
    output bellmanFordPkg::distance_t     outData,
    output logic                          pathDone
);
    typedef enum logic [1:0] {stateIdle, stateHead, stateNodes, stateEnd} walkState_t;

    walkState_t                    state;
    bellmanFordPkg::nodeId_t       currentNode;
    bellmanFordPkg::nodeId_t       sourceReg;
    bellmanFordPkg::nodeId_t       steps;
    bellmanFordPkg::graphAddress_t nextAddress;

    assign pathNode = currentNode;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= stateIdle;
            outWriteEnable <= 1'b0;
            pathDone <= 1'b0;
        end
        else
        begin
            // One word per cycle in every active state
            outWriteEnable <= state != stateIdle;
            pathDone <= 1'b0;
            case (state)
                stateIdle:
                begin
                    if (walkStart)
                        state <= stateHead;
                end
                stateHead:
                begin
                    pathDone <= !pathReached;
                    state <= pathReached ? stateNodes : stateIdle;
                end
                stateNodes:
                begin
                    if (currentNode == sourceReg)
                        state <= stateEnd;
                end
                default:
                begin
                    pathDone <= 1'b1;
                    state <= stateIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        case (state)
            stateIdle:
            begin
                currentNode <= walkDestination;
                sourceReg <= walkSource;
                steps <= '0;
                nextAddress <= '0;
            end
            stateHead:
                outData <= pathReached ? pathDistance : `BF_PATH_END;
            stateNodes:
            begin
                outData <= bellmanFordPkg::distance_t'(currentNode);
                currentNode <= pathPredecessor;
                steps <= steps + 1'b1;
            end
            default:
                outData <= `BF_PATH_END;
        endcase
        if (state != stateIdle)
        begin
            outAddress <= nextAddress;
            nextAddress <= nextAddress + 1'b1;
        end
    end

    walkBounded: assert property (@(posedge clock) disable iff (reset)
        state == stateNodes |-> steps < `BF_MAX_NODES);

endmodule

// File: source/bellmanFordTop.sv
`include "bellmanFordConsts.svh"

module bellmanFordTop (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          start,
    input  bellmanFordPkg::nodeId_t       source,
    input  bellmanFordPkg::nodeId_t       destination,
    input  bellmanFordPkg::nodeId_t       nodeCount,
    output logic                          graphReadEnable,
    output bellmanFordPkg::graphAddress_t graphAddress,
    input  bellmanFordPkg::graphLine_t    graphData,
    output logic                          outWriteEnable,
    output bellmanFordPkg::graphAddress_t outAddress,
    output bellmanFordPkg::distance_t     outData,
    output logic                          busy,
    output logic                          finish,
    output logic                          negCycle
);
    logic                      initialize;
    bellmanFordPkg::nodeId_t   initNode;
    logic                      writeEnable;
    bellmanFordPkg::nodeId_t   writeNode;
    bellmanFordPkg::nodeId_t   writePredecessor;
    bellmanFordPkg::distance_t writeDistance;
    bellmanFordPkg::nodeId_t   scanNode;
    logic                      scanReached;
    bellmanFordPkg::distance_t scanDistance;
    bellmanFordPkg::nodeId_t   relaxNode;
    logic                      relaxReached;
    bellmanFordPkg::distance_t relaxDistance;
    bellmanFordPkg::nodeId_t   pathNode;
    logic                      pathReached;
    bellmanFordPkg::distance_t pathDistance;
    bellmanFordPkg::nodeId_t   pathPredecessor;
    logic                      fetchStart;
    bellmanFordPkg::nodeId_t   fetchNode;
    logic                      fetchDone;
    logic                      edgeValid;
    bellmanFordPkg::nodeId_t   edgeNode;
    bellmanFordPkg::weight_t   edgeWeight;
    bellmanFordPkg::nodeId_t   sourceNode;
    bellmanFordPkg::distance_t sourceDistance;
    logic                      relaxerIdle;
    logic                      walkStart;
    bellmanFordPkg::nodeId_t   walkSource;
    bellmanFordPkg::nodeId_t   walkDestination;
    logic                      pathDone;

    distanceTable distances (.*);

    adjacencyFetch fetch (.*);

    edgeRelaxer relaxer (.*);

    // Table write strobe doubles as the update flag
    passController controller (.*, .updated(writeEnable));

    pathWriter writer (.*);

endmodule

// File: verif/graphMemoryModel.sv
`include "bellmanFordConsts.svh"

module graphMemoryModel (
    input  logic                          clock,
    input  logic                          readEnable,
    input  bellmanFordPkg::graphAddress_t readAddress,
    output bellmanFordPkg::graphLine_t    readData,
    input  logic                          writeEnable,
    input  bellmanFordPkg::graphAddress_t writeAddress,
    input  bellmanFordPkg::graphLine_t    writeData
);
    bellmanFordPkg::graphLine_t lines [2**`BF_ADDR_WIDTH];

    // Registered read, data follows one cycle after the request
    always @(posedge clock)
    begin
        if (writeEnable)
            lines[writeAddress] <= writeData;
        if (readEnable)
            readData <= lines[readAddress];
    end

endmodule

// File: verif/bellmanFordTb.sv
`include "bellmanFordConsts.svh"

module bellmanFordTb;
    localparam int maxNodes = 12;
    localparam int maxLinks = 16;
    localparam int lineBase = 64;
    localparam int resetCycles = 16;
    localparam int queryCount = 25;
    localparam int cyclesPerEdge = 40;
    localparam int timeoutLimit =
        resetCycles + queryCount * maxNodes * maxNodes * cyclesPerEdge;

    logic                          clock = 1'b0;
    logic                          reset = 1'b1;
    logic                          start = 1'b0;
    bellmanFordPkg::nodeId_t       source = 8'd1;
    bellmanFordPkg::nodeId_t       destination = 8'd1;
    bellmanFordPkg::nodeId_t       nodeCount = 8'd1;
    logic                          graphReadEnable;
    bellmanFordPkg::graphAddress_t graphAddress;
    bellmanFordPkg::graphLine_t    graphData;
    logic                          outWriteEnable;
    bellmanFordPkg::graphAddress_t outAddress;
    bellmanFordPkg::distance_t     outData;
    logic                          busy;
    logic                          finish;
    logic                          negCycle;

    logic                          memWrite = 1'b0;
    bellmanFordPkg::graphAddress_t memAddress = '0;
    bellmanFordPkg::graphLine_t    memData = '0;

    // Software copy of the graph
    int          linkCount [maxNodes+1];
    int          neighbor [maxNodes+1][maxLinks];
    int          weight [maxNodes+1][maxLinks];
    logic [15:0] expectedWords [64];
    int          expectedCount = 0;
    logic        expectedNeg = 1'b0;
    int          wordCount = 0;
    int          cycleCount = 0;
    integer      seed = 57;

    bellmanFordTop uut (.*);

    graphMemoryModel memory (
        .clock(clock),
        .readEnable(graphReadEnable),
        .readAddress(graphAddress),
        .readData(graphData),
        .writeEnable(memWrite),
        .writeAddress(memAddress),
        .writeData(memData)
    );

    always #4 clock = ~clock;

    task automatic stopWithFailure(input string message);
        $display("%s", message);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped");
    endtask

    function automatic int pickInRange(input int low, input int high);
        int span;
        span = high - low + 1;
        return low + int'($unsigned($random(seed)) % span);
    endfunction

    task automatic clearGraph();
        for (int u = 0; u <= maxNodes; u++)
            linkCount[u] = 0;
    endtask

    task automatic addEdge(input int from, input int to, input int cost);
        neighbor[from][linkCount[from]] = to;
        weight[from][linkCount[from]] = cost;
        linkCount[from]++;
    endtask

    task automatic appendWord(input logic [15:0] word);
        expectedWords[expectedCount] = word;
        expectedCount++;
    endtask

    // In-place relaxation in node order, as many passes as nodes
    task automatic computeExpected(input int src, input int dst, input int n);
        bit reached [maxNodes+1];
        int bestDist [maxNodes+1];
        int pred [maxNodes+1];
        int base;
        int node;
        int candidate;
        int steps;
        bit changed;
        bit converged;
        for (int u = 0; u <= maxNodes; u++)
            reached[u] = 1'b0;
        reached[src] = 1'b1;
        bestDist[src] = 0;
        pred[src] = src;
        converged = 1'b0;
        expectedNeg = 1'b0;
        expectedCount = 0;
        for (int pass = 1; pass <= n && !converged && !expectedNeg; pass++)
        begin
            changed = 1'b0;
            for (int u = 1; u <= n; u++)
            begin
                if (reached[u])
                begin
                    base = bestDist[u];
                    for (int k = 0; k < linkCount[u]; k++)
                    begin
                        node = neighbor[u][k];
                        candidate = base + weight[u][k];
                        if (!reached[node] || candidate < bestDist[node])
                        begin
                            reached[node] = 1'b1;
                            bestDist[node] = candidate;
                            pred[node] = u;
                            changed = 1'b1;
                        end
                    end
                end
            end
            if (!changed)
                converged = 1'b1;
            else if (pass == n)
                expectedNeg = 1'b1;
        end
        if (converged && !reached[dst])
            appendWord(`BF_PATH_END);
        else if (converged)
        begin
            appendWord(16'(bestDist[dst]));
            node = dst;
            appendWord(16'(node));
            steps = 0;
            while (node != src && steps < maxNodes)
            begin
                node = pred[node];
                appendWord(16'(node));
                steps++;
            end
            appendWord(`BF_PATH_END);
        end
    endtask

    task automatic writeLine(input int address, input bellmanFordPkg::graphLine_t data);
        @(posedge clock);
        memWrite <= 1'b1;
        memAddress <= bellmanFordPkg::graphAddress_t'(address);
        memData <= data;
    endtask

    // Index words at 1..n and adjacency lines from lineBase upward
    task automatic loadGraph(input int n);
        bellmanFordPkg::graphLine_t lines [3];
        int address;
        int lineNo;
        int slot;
        int lineTotal;
        address = lineBase;
        for (int u = 1; u <= n; u++)
        begin
            writeLine(u, bellmanFordPkg::graphLine_t'(address));
            for (int l = 0; l < 3; l++)
                lines[l] = '0;
            lines[0][`BF_COUNT_MSB:`BF_COUNT_LSB] = 8'(linkCount[u]);
            for (int k = 0; k < linkCount[u]; k++)
            begin
                if (k < `BF_FIRST_PAIRS)
                begin
                    lineNo = 0;
                    slot = k + 1;
                end
                else
                begin
                    lineNo = 1 + (k - `BF_FIRST_PAIRS) / `BF_NEXT_PAIRS;
                    slot = (k - `BF_FIRST_PAIRS) % `BF_NEXT_PAIRS;
                end
                lines[lineNo][127 - 16 * slot -: 8] = 8'(neighbor[u][k]);
                lines[lineNo][119 - 16 * slot -: 8] = 8'(weight[u][k]);
            end
            lineTotal = 1;
            if (linkCount[u] > `BF_FIRST_PAIRS)
                lineTotal = 1 + (linkCount[u] - `BF_FIRST_PAIRS + 7) / `BF_NEXT_PAIRS;
            for (int l = 0; l < lineTotal; l++)
                writeLine(address + l, lines[l]);
            address = address + lineTotal;
        end
        @(posedge clock);
        memWrite <= 1'b0;
    endtask

    task automatic buildRandomGraph(input int n);
        int links;
        clearGraph();
        for (int u = 1; u <= n; u++)
        begin
            links = pickInRange(0, 11);
            for (int k = 0; k < links; k++)
                addEdge(u, pickInRange(1, n), pickInRange(-2, 15));
        end
    endtask

    task automatic runQuery(input int src, input int dst, input int n);
        @(negedge clock);
        computeExpected(src, dst, n);
        loadGraph(n);
        @(posedge clock);
        start <= 1'b1;
        source <= 8'(src);
        destination <= 8'(dst);
        nodeCount <= 8'(n);
        @(posedge clock);
        start <= 1'b0;
        @(negedge clock);
        while (finish !== 1'b1)
            @(negedge clock);
        @(posedge clock);
    endtask

    always @(posedge clock)
    begin
        if (reset || start)
            wordCount <= 0;
        else if (outWriteEnable)
            wordCount <= wordCount + 1;
    end

    always @(posedge clock)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit)
            stopWithFailure($sformatf("Run timed out after %0d cycles", cycleCount));
    end

    wordMatches: assert property (@(posedge clock) disable iff (reset)
        outWriteEnable |-> outAddress < expectedCount && outData == expectedWords[outAddress])
    else
        stopWithFailure($sformatf("mismatch at time %0t: word %0d is %h, expected %h",
            $time, $sampled(outAddress), $sampled(outData),
            expectedWords[$sampled(outAddress)]));

    resultAtFinish: assert property (@(posedge clock) disable iff (reset)
        finish |-> negCycle == expectedNeg && wordCount == expectedCount)
    else
        stopWithFailure($sformatf("mismatch at time %0t: negCycle %b with %0d words, %s %b %0d",
            $time, $sampled(negCycle), $sampled(wordCount), "expected",
            expectedNeg, expectedCount));

    quietAfterReset: assert property (@(posedge clock)
        reset |=> !busy && !finish && !outWriteEnable && !negCycle && !graphReadEnable)
    else
        stopWithFailure($sformatf("mismatch at time %0t: DUT outputs active after reset",
            $time));

    finishWhileBusy: assert property (@(posedge clock) disable iff (reset)
        finish |-> busy)
    else
        stopWithFailure($sformatf("mismatch at time %0t: finish while not busy", $time));

    initial
    begin
        int n;
        int src;
        int dst;
        repeat (resetCycles) @(posedge clock);
        reset <= 1'b0;

        // Source with eleven links spans a first and a continuation line
        clearGraph();
        for (int v = 2; v <= 12; v++)
            addEdge(1, v, 5 * (v - 1));
        addEdge(2, 12, 1);
        addEdge(3, 4, 2);
        runQuery(1, 12, 12);

        // Negative edge 2 to 3 wins over the direct path
        clearGraph();
        addEdge(1, 2, 4);
        addEdge(1, 3, 2);
        addEdge(2, 3, -3);
        addEdge(2, 4, 10);
        addEdge(3, 4, 5);
        addEdge(4, 5, -2);
        runQuery(1, 5, 5);

        // Same graph with source as destination
        runQuery(2, 2, 5);

        // Node 4 cannot be reached from node 1
        clearGraph();
        addEdge(1, 2, 3);
        addEdge(2, 1, 1);
        addEdge(3, 4, 2);
        runQuery(1, 4, 4);

        // Cycle 2-3-2 has weight -1
        clearGraph();
        addEdge(1, 2, 1);
        addEdge(2, 3, -2);
        addEdge(3, 2, 1);
        addEdge(3, 4, 1);
        runQuery(1, 4, 4);

        for (int q = 0; q < 20; q++)
        begin
            n = pickInRange(4, 10);
            buildRandomGraph(n);
            src = pickInRange(1, n);
            dst = pickInRange(1, n);
            runQuery(src, dst, n);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: all.f
+incdir+source
source/bellmanFordPkg.sv
source/distanceTable.sv
source/adjacencyFetch.sv
source/edgeRelaxer.sv
source/passController.sv
source/pathWriter.sv
source/bellmanFordTop.sv
verif/graphMemoryModel.sv
verif/bellmanFordTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module bellmanFordTb -o simBellmanFord

./obj_dir/simBellmanFord > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    exit 0
fi
exit 1
